// File: design/cpu_pkg.sv
// ==========================================================
// Unknown opcode classes decode as no-operation.
// Only Z and C exist in the flag register; other bits read 0.
// ==========================================================
package cpu_pkg;

    // opcode class, instruction bits 15..12
    typedef enum logic [3:0] {
        OP_LDI  = 4'h1,
        OP_ALU  = 4'h2,
        OP_LD   = 4'h3,
        OP_ST   = 4'h4,
        OP_STB  = 4'h5,
        OP_JNZ  = 4'h6,
        OP_HALT = 4'hf
    } op_class_e;

    // ALU operation, bits 2..0 of an ALU instruction
    typedef enum logic [2:0] {
        ALU_ADD = 3'd0,
        ALU_SUB = 3'd1,
        ALU_AND = 3'd2,
        ALU_OR  = 3'd3,
        ALU_XOR = 3'd4
    } alu_op_e;

    // flag register bit positions
    localparam int FLAG_Z = 0;
    localparam int FLAG_C = 1;

    // instruction fields
    localparam int OPC_HI = 15;
    localparam int OPC_LO = 12;
    localparam int DST_HI = 11;
    localparam int DST_LO = 9;
    localparam int SRC_HI = 8;
    localparam int SRC_LO = 6;
    localparam int ALU_HI = 2;
    localparam int ALU_LO = 0;

    localparam int NUM_REGS = 8;

endpackage

// File: design/cpu_alu.sv
// ==========================================================
// Purely combinational. Operand a is the destination register.
// C is carry on add, borrow on subtract, cleared otherwise.
// ==========================================================
`timescale 1ns/1ns

module cpu_alu
    import cpu_pkg::*;
(
    input        [15:0] a,
    input        [15:0] b,
    input  alu_op_e     alu_op,
    output logic [15:0] result,
    output logic  [7:0] flags_out
);

    logic [16:0] wide;

    always_comb begin
        wide = '0;
        case (alu_op)
            ALU_ADD: begin
                wide = {1'b0, a} + {1'b0, b};
            end
            ALU_SUB: begin
                // bit 16 ends up as the borrow
                wide = {1'b0, a} - {1'b0, b};
            end
            ALU_AND: begin
                wide = {1'b0, a & b};
            end
            ALU_OR: begin
                wide = {1'b0, a | b};
            end
            ALU_XOR: begin
                wide = {1'b0, a ^ b};
            end
            default: begin
                wide = '0;
            end
        endcase
    end

    assign result = wide[15:0];

    always_comb begin
        flags_out         = '0;
        flags_out[FLAG_Z] = (wide[15:0] == 16'd0);
        flags_out[FLAG_C] = wide[16];
    end

endmodule

// File: design/cpu_regs.sv
// ==========================================================
// Register writes and flag writes take effect on enabled edges.
// Dump port is combinational; 0..15 map to register bytes.
// ==========================================================
`timescale 1ns/1ns

module cpu_regs
    import cpu_pkg::*;
(
    input              clk,
    input              arst_n,
    input              cen,
    input        [2:0] rd_a_sel,
    input        [2:0] rd_b_sel,
    input        [2:0] wr_sel,
    input              wr_en,
    input       [15:0] wr_data,
    input              flags_we,
    input        [7:0] flags_in,
    input        [7:0] dmp_addr,
    output      [15:0] rd_a,
    output      [15:0] rd_b,
    output       [7:0] flags,
    output logic [7:0] dmp_din
);

    // only Z and C are kept
    localparam logic [7:0] FLAGS_MASK = 8'((1 << FLAG_Z) | (1 << FLAG_C));

    logic [15:0] regs_q [NUM_REGS];
    logic  [7:0] flags_q;
    logic [15:0] dmp_word;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            for (int i = 0; i < NUM_REGS; i++) begin
                regs_q[i] <= '0;
            end
            flags_q <= '0;
        end else if (cen) begin
            if (wr_en) begin
                regs_q[wr_sel] <= wr_data;
            end
            if (flags_we) begin
                flags_q <= flags_in & FLAGS_MASK;
            end
        end
    end

    assign rd_a  = regs_q[rd_a_sel];
    assign rd_b  = regs_q[rd_b_sel];
    assign flags = flags_q;

    // even address is the low byte
    assign dmp_word = regs_q[dmp_addr[3:1]];

    always_comb begin
        if (dmp_addr < 8'd16) begin
            dmp_din = dmp_addr[0] ? dmp_word[15:8] : dmp_word[7:0];
        end else if (dmp_addr == 8'd16) begin
            dmp_din = flags_q;
        end else begin
            dmp_din = '0;
        end
    end

endmodule

// File: design/cpu_ramctl.sv
// ==========================================================
// RAM read data appears one enabled cycle after the address.
// No back-pressure. Word accesses are forced to even addresses.
// ==========================================================
`timescale 1ns/1ns

module cpu_ramctl #(
    parameter int ADDR_W = 24
) (
    input               clk,
    input               arst_n,
    input               cen,
    input               mem_req,
    input               mem_wr,
    input               mem_byte,
    input  [ADDR_W-1:0] mem_addr,
    input        [15:0] mem_wdata,
    input        [15:0] ram_dout,
    output              mem_done,
    output       [15:0] mem_rdata,
    output [ADDR_W-1:0] ram_addr,
    output       [15:0] ram_din,
    output        [1:0] ram_we
);

    logic       rd_wait;
    logic [1:0] lanes;

    // second cycle of a read, RAM word is now on ram_dout
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            rd_wait <= 1'b0;
        end else if (cen) begin
            rd_wait <= mem_req && !mem_wr && !rd_wait;
        end
    end

    // odd byte address selects the high lane
    assign lanes = mem_byte ? (mem_addr[0] ? 2'b10 : 2'b01) : 2'b11;

    assign ram_addr = mem_byte ? mem_addr : {mem_addr[ADDR_W-1:1], 1'b0};
    assign ram_din  = mem_byte ? {mem_wdata[7:0], mem_wdata[7:0]} : mem_wdata;
    assign ram_we   = (mem_req && mem_wr) ? lanes : 2'b00;

    // writes finish in their first cycle
    assign mem_done  = mem_req && (mem_wr || rd_wait);
    assign mem_rdata = ram_dout;

endmodule

// File: design/cpu_ctrl.sv
// ==========================================================
// Multicycle: fetch, optional second word or memory access,
// then write-back. Halt is held until reset.
// ==========================================================
`timescale 1ns/1ns

module cpu_ctrl
    import cpu_pkg::*;
#(
    parameter int ADDR_W = 24
) (
    input                     clk,
    input                     arst_n,
    input                     cen,
    input                     mem_done,
    input              [15:0] mem_rdata,
    input              [15:0] rd_a,
    input              [15:0] rd_b,
    input              [15:0] alu_result,
    input               [7:0] alu_flags,
    input               [7:0] flags,
    output logic              mem_req,
    output logic              mem_wr,
    output logic              mem_byte,
    output logic [ADDR_W-1:0] mem_addr,
    output             [15:0] mem_wdata,
    output              [2:0] rd_a_sel,
    output              [2:0] rd_b_sel,
    output alu_op_e           alu_op,
    output              [2:0] wr_sel,
    output logic              wr_en,
    output logic       [15:0] wr_data,
    output logic              flags_we,
    output                    halted
);

    typedef enum logic [2:0] {
        S_FETCH,
        S_FETCH2,
        S_MEM,
        S_WB,
        S_HALT
    } state_e;

    state_e            state;
    logic [ADDR_W-1:0] pc_q;
    logic       [15:0] ir_q;
    logic       [15:0] data_q;
    op_class_e         op_q;
    op_class_e         op_new;

    assign op_q   = op_class_e'(ir_q[OPC_HI:OPC_LO]);
    assign op_new = op_class_e'(mem_rdata[OPC_HI:OPC_LO]);

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            state <= S_FETCH;
            pc_q  <= '0;
            ir_q  <= '0;
        end else if (cen) begin
            case (state)
                S_FETCH: begin
                    if (mem_done) begin
                        ir_q <= mem_rdata;
                        pc_q <= pc_q + ADDR_W'(2);
                        case (op_new)
                            OP_LDI, OP_JNZ:      state <= S_FETCH2;
                            OP_LD, OP_ST, OP_STB: state <= S_MEM;
                            OP_HALT:             state <= S_HALT;
                            default:             state <= S_WB;
                        endcase
                    end
                end
                S_FETCH2: begin
                    if (mem_done) begin
                        pc_q  <= pc_q + ADDR_W'(2);
                        state <= S_WB;
                    end
                end
                S_MEM: begin
                    if (mem_done) begin
                        state <= S_WB;
                    end
                end
                S_WB: begin
                    // jump taken when zero is clear
                    if (op_q == OP_JNZ && !flags[FLAG_Z]) begin
                        pc_q <= ADDR_W'(data_q);
                    end
                    state <= S_FETCH;
                end
                default: begin
                    state <= S_HALT;
                end
            endcase
        end
    end

    // second word or loaded word
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            data_q <= '0;
        end else if (cen && mem_done && state != S_FETCH) begin
            data_q <= mem_rdata;
        end
    end

    assign mem_req   = (state == S_FETCH) || (state == S_FETCH2) || (state == S_MEM);
    assign mem_wr    = (state == S_MEM) && (op_q == OP_ST || op_q == OP_STB);
    assign mem_byte  = (state == S_MEM) && (op_q == OP_STB);
    assign mem_addr  = (state == S_MEM) ? ADDR_W'(rd_b) : pc_q;
    assign mem_wdata = rd_a;

    assign rd_a_sel = ir_q[DST_HI:DST_LO];
    assign rd_b_sel = ir_q[SRC_HI:SRC_LO];
    assign wr_sel   = ir_q[DST_HI:DST_LO];
    assign alu_op   = alu_op_e'(ir_q[ALU_HI:ALU_LO]);

    assign wr_en   = (state == S_WB) && (op_q == OP_LDI || op_q == OP_ALU || op_q == OP_LD);
    assign wr_data = (op_q == OP_ALU) ? alu_result : data_q;

    // flag register only toggles when a value changes
    assign flags_we = (state == S_WB) && (op_q == OP_ALU) && (alu_flags != flags);

    assign halted = (state == S_HALT);

endmodule

// File: design/cpu_core.sv
// ==========================================================
// State advances only on clk edges with cen high.
// Program starts at address 0; halted holds until reset.
// ==========================================================
`timescale 1ns/1ns

module cpu_core
    import cpu_pkg::*;
#(
    parameter int ADDR_W = 24
) (
    input               clk,
    input               arst_n,
    input               cen,

    output [ADDR_W-1:0] ram_addr,
    input        [15:0] ram_dout,
    output       [15:0] ram_din,
    output        [1:0] ram_we,
    // register dump
    input         [7:0] dmp_addr,
    output        [7:0] dmp_din,

    output              halted
);

    // controller to RAM sequencer
    logic              mem_req, mem_wr, mem_byte, mem_done;
    logic [ADDR_W-1:0] mem_addr;
    logic       [15:0] mem_wdata, mem_rdata;

    // register bank
    logic  [2:0] rd_a_sel, rd_b_sel, wr_sel;
    logic        wr_en, flags_we;
    logic [15:0] wr_data, rd_a, rd_b;
    logic  [7:0] flags;

    // ALU
    alu_op_e     alu_op;
    logic [15:0] alu_result;
    logic  [7:0] alu_flags;

    cpu_ctrl #(.ADDR_W(ADDR_W)) u_ctrl (
        .clk        ( clk        ),
        .arst_n     ( arst_n     ),
        .cen        ( cen        ),
        .mem_done   ( mem_done   ),
        .mem_rdata  ( mem_rdata  ),
        .rd_a       ( rd_a       ),
        .rd_b       ( rd_b       ),
        .alu_result ( alu_result ),
        .alu_flags  ( alu_flags  ),
        .flags      ( flags      ),
        .mem_req    ( mem_req    ),
        .mem_wr     ( mem_wr     ),
        .mem_byte   ( mem_byte   ),
        .mem_addr   ( mem_addr   ),
        .mem_wdata  ( mem_wdata  ),
        .rd_a_sel   ( rd_a_sel   ),
        .rd_b_sel   ( rd_b_sel   ),
        .alu_op     ( alu_op     ),
        .wr_sel     ( wr_sel     ),
        .wr_en      ( wr_en      ),
        .wr_data    ( wr_data    ),
        .flags_we   ( flags_we   ),
        .halted     ( halted     )
    );

    cpu_regs u_regs (
        .clk      ( clk       ),
        .arst_n   ( arst_n    ),
        .cen      ( cen       ),
        .rd_a_sel ( rd_a_sel  ),
        .rd_b_sel ( rd_b_sel  ),
        .wr_sel   ( wr_sel    ),
        .wr_en    ( wr_en     ),
        .wr_data  ( wr_data   ),
        .flags_we ( flags_we  ),
        .flags_in ( alu_flags ),
        .dmp_addr ( dmp_addr  ),
        .rd_a     ( rd_a      ),
        .rd_b     ( rd_b      ),
        .flags    ( flags     ),
        .dmp_din  ( dmp_din   )
    );

    cpu_alu u_alu (
        .a         ( rd_a       ),
        .b         ( rd_b       ),
        .alu_op    ( alu_op     ),
        .result    ( alu_result ),
        .flags_out ( alu_flags  )
    );

    cpu_ramctl #(.ADDR_W(ADDR_W)) u_ramctl (
        .clk       ( clk       ),
        .arst_n    ( arst_n    ),
        .cen       ( cen       ),
        .mem_req   ( mem_req   ),
        .mem_wr    ( mem_wr    ),
        .mem_byte  ( mem_byte  ),
        .mem_addr  ( mem_addr  ),
        .mem_wdata ( mem_wdata ),
        .ram_dout  ( ram_dout  ),
        .mem_done  ( mem_done  ),
        .mem_rdata ( mem_rdata ),
        .ram_addr  ( ram_addr  ),
        .ram_din   ( ram_din   ),
        .ram_we    ( ram_we    )
    );

endmodule

// File: tests/cpu_assertions.sv
// ==========================================================
// Bound into cpu_core. Sampled on every clk edge, cen ignored.
// ==========================================================
`timescale 1ns/1ns

module cpu_assertions #(
    parameter int ADDR_W = 24
) (
    input              clk,
    input              arst_n,
    input [ADDR_W-1:0] ram_addr,
    input        [1:0] ram_we,
    input              halted
);

    int fail_count = 0;

    we_idle_in_reset: assert property (@(posedge clk) !arst_n |-> ram_we == 2'b00)
        else begin
            fail_count++;
            $error("ram_we active while reset is asserted");
        end

    we_idle_when_halted: assert property (@(posedge clk) halted |-> ram_we == 2'b00)
        else begin
            fail_count++;
            $error("ram_we active after halt");
        end

    // both lanes means a word store
    word_write_even: assert property (@(posedge clk) disable iff (!arst_n)
        ram_we == 2'b11 |-> !ram_addr[0])
        else begin
            fail_count++;
            $error("word write to odd address");
        end

    halt_sticky: assert property (@(posedge clk) disable iff (!arst_n) halted |=> halted)
        else begin
            fail_count++;
            $error("halted fell without reset");
        end

endmodule

bind cpu_core cpu_assertions #(.ADDR_W(ADDR_W)) u_assertions (
    .clk      ( clk      ),
    .arst_n   ( arst_n   ),
    .ram_addr ( ram_addr ),
    .ram_we   ( ram_we   ),
    .halted   ( halted   )
);

// File: tests/cpu_tb.sv
// ==========================================================
// Directed programs run from address 0; results read via dump.
// RAM model holds 32K words, only ram_addr[15:1] is decoded.
// ==========================================================
`timescale 1ns/1ns

module cpu_tb
    import cpu_pkg::*;
;

    localparam int RAM_WORDS = 32768;
    localparam logic [31:0] SEED = 32'h69954476;
    // instructions per test, countdown counted at its largest n
    localparam int WORST_INSNS = 1 + 9 + 15 * 6 + 11 + 37 + 3;
    localparam int NUM_PROGRAMS = 20;
    // 10 enabled cycles per instruction, cen high half the time
    localparam int WATCHDOG_CYCLES = WORST_INSNS * 10 * 2 + NUM_PROGRAMS * 64 + 512;

    logic        clk;
    logic        arst_n;
    logic        cen;
    logic [23:0] ram_addr;
    logic [15:0] ram_dout;
    logic [15:0] ram_din;
    logic  [1:0] ram_we;
    logic  [7:0] dmp_addr;
    logic  [7:0] dmp_din;
    logic        halted;

    logic [15:0] mem [RAM_WORDS];
    logic [15:0] image [RAM_WORDS];
    int          ptr;
    int          errors;
    int          checks;
    int          tests;
    logic [31:0] cen_lfsr = SEED;
    logic [31:0] data_lfsr = SEED;

    cpu_core #(.ADDR_W(24)) dut (
        .clk      ( clk      ),
        .arst_n   ( arst_n   ),
        .cen      ( cen      ),
        .ram_addr ( ram_addr ),
        .ram_dout ( ram_dout ),
        .ram_din  ( ram_din  ),
        .ram_we   ( ram_we   ),
        .dmp_addr ( dmp_addr ),
        .dmp_din  ( dmp_din  ),
        .halted   ( halted   )
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        // x^32 + x^22 + x^2 + x + 1
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    initial begin
        cen = 1'b0;
        forever begin
            @(posedge clk);
            cen_lfsr = lfsr_step(cen_lfsr);
            cen <= cen_lfsr[0];
        end
    end

    // RAM: program image copied in during reset, one enabled cycle read latency
    initial begin
        ram_dout = 16'd0;
        forever begin
            @(posedge clk);
            if (!arst_n) begin
                for (int i = 0; i < RAM_WORDS; i++) begin
                    mem[i] <= image[i];
                end
            end else if (cen) begin
                ram_dout <= mem[ram_addr[15:1]];
                if (ram_we[0]) begin
                    mem[ram_addr[15:1]][7:0] <= ram_din[7:0];
                end
                if (ram_we[1]) begin
                    mem[ram_addr[15:1]][15:8] <= ram_din[15:8];
                end
            end
        end
    end

    initial begin
        #(WATCHDOG_CYCLES * 8);
        $display("watchdog expired: tests did not finish in %0d cycles", WATCHDOG_CYCLES);
        $display("CHECKS FAILED");
        $finish;
    end

    task automatic rand16(output logic [15:0] v);
        v = 16'd0;
        for (int i = 0; i < 16; i++) begin
            data_lfsr = lfsr_step(data_lfsr);
            v = {v[14:0], data_lfsr[0]};
        end
    endtask

    function automatic logic [15:0] fill_word(input int i);
        return 16'(i) * 16'h9e37 + 16'h3c5a;
    endfunction

    function automatic logic [15:0] enc(input logic [3:0] op, input int d, input int s,
                                        input logic [2:0] f);
        return {op, 3'(d), 3'(s), 3'b000, f};
    endfunction

    // {carry, zero, result}
    function automatic logic [17:0] alu_expect(input alu_op_e op, input logic [15:0] a,
                                               input logic [15:0] b);
        logic [16:0] sum;
        logic [15:0] res;
        logic        c;
        c = 1'b0;
        case (op)
            ALU_ADD: begin
                sum = 17'(a) + 17'(b);
                res = sum[15:0];
                c = sum[16];
            end
            ALU_SUB: begin
                res = a - b;
                c = (a < b);
            end
            ALU_AND: res = a & b;
            ALU_OR:  res = a | b;
            ALU_XOR: res = a ^ b;
            default: res = 16'd0;
        endcase
        return {c, res == 16'd0, res};
    endfunction

    task automatic clear_image();
        for (int i = 0; i < RAM_WORDS; i++) begin
            image[i] = fill_word(i);
        end
        ptr = 0;
    endtask

    task automatic put(input logic [15:0] w);
        image[ptr] = w;
        ptr++;
    endtask

    task automatic put_ldi(input int d, input logic [15:0] v);
        put(enc(OP_LDI, d, 0, 3'd0));
        put(v);
    endtask

    task automatic put_alu(input alu_op_e op, input int d, input int s);
        put(enc(OP_ALU, d, s, op));
    endtask

    task automatic apply_reset();
        @(posedge clk);
        arst_n <= 1'b0;
        dmp_addr <= 8'd0;
        repeat (16) @(posedge clk);
        arst_n <= 1'b1;
    endtask

    task automatic wait_halt(input string name, input int insns);
        int n;
        n = 0;
        while (halted !== 1'b1 && n < insns * 20 + 64) begin
            @(negedge clk);
            n++;
        end
        if (halted !== 1'b1) begin
            errors++;
            $display("%s: program did not halt within %0d cycles", name, n);
        end
    endtask

    task automatic read_byte(input int a, output logic [7:0] v);
        @(posedge clk);
        dmp_addr <= 8'(a);
        @(negedge clk);
        v = dmp_din;
    endtask

    task automatic read_reg(input int r, output logic [15:0] v);
        logic [7:0] lo;
        logic [7:0] hi;
        read_byte(2 * r, lo);
        read_byte(2 * r + 1, hi);
        v = {hi, lo};
    endtask

    task automatic check(input string name, input logic [15:0] expected,
                         input logic [15:0] actual);
        checks++;
        if (actual !== expected) begin
            errors++;
            $display("MISMATCH %s: expected %h, actual %h", name, expected, actual);
        end
    endtask

    task automatic end_test(input string name, input int errs_before);
        tests++;
        $display("%s: %s", name, (errors == errs_before) ? "ok" : "failed");
    endtask

    task automatic reset_defaults();
        int          e0;
        logic  [7:0] b;
        e0 = errors;
        clear_image();
        put(enc(OP_HALT, 0, 0, 3'd0));
        apply_reset();
        @(negedge clk);
        check("reset_defaults halted", 16'd0, 16'(halted));
        check("reset_defaults ram_we", 16'd0, 16'(ram_we));
        for (int a = 0; a < 256; a++) begin
            read_byte(a, b);
            check($sformatf("reset_defaults dump %0d", a), 16'd0, 16'(b));
        end
        wait_halt("reset_defaults", 1);
        end_test("reset_defaults", e0);
    endtask

    task automatic load_all_registers();
        int          e0;
        logic [15:0] vals [8];
        logic [15:0] v;
        logic  [7:0] f;
        e0 = errors;
        clear_image();
        for (int r = 0; r < 8; r++) begin
            rand16(vals[r]);
            put_ldi(r, vals[r]);
        end
        put(enc(OP_HALT, 0, 0, 3'd0));
        apply_reset();
        wait_halt("load_all_registers", 9);
        for (int r = 0; r < 8; r++) begin
            read_reg(r, v);
            check($sformatf("load_all_registers r%0d", r), vals[r], v);
        end
        read_byte(16, f);
        check("load_all_registers flags", 16'd0, 16'(f));
        end_test("load_all_registers", e0);
    endtask

    task automatic alu_operations();
        int          e0;
        alu_op_e     op;
        logic [15:0] a;
        logic [15:0] b;
        logic [15:0] v;
        logic [17:0] exp;
        logic  [7:0] f;
        string       name;
        e0 = errors;
        for (int k = 0; k < 5; k++) begin
            op = alu_op_e'(3'(k));
            for (int rnd = 0; rnd < 3; rnd++) begin
                name = $sformatf("alu_operations op%0d round%0d", k, rnd);
                rand16(a);
                rand16(b);
                // last round aims at a zero result
                if (rnd == 2) begin
                    case (op)
                        ALU_ADD: b = ~a + 16'd1;
                        ALU_AND: b = ~a;
                        ALU_OR: begin
                            a = 16'd0;
                            b = 16'd0;
                        end
                        default: b = a;
                    endcase
                end
                exp = alu_expect(op, a, b);
                clear_image();
                // 8000 + 8000 leaves Z and C both set before the tested op
                put_ldi(3, 16'h8000);
                put_alu(ALU_ADD, 3, 3);
                put_ldi(1, a);
                put_ldi(2, b);
                put_alu(op, 1, 2);
                put(enc(OP_HALT, 0, 0, 3'd0));
                apply_reset();
                wait_halt(name, 6);
                read_reg(1, v);
                check({name, " result"}, exp[15:0], v);
                read_reg(2, v);
                check({name, " source"}, b, v);
                read_byte(16, f);
                check({name, " flags"}, {14'd0, exp[17], exp[16]}, 16'(f));
            end
        end
        end_test("alu_operations", e0);
    endtask

    task automatic store_and_load();
        int          e0;
        logic [15:0] data;
        logic [15:0] bval;
        logic [15:0] w801;
        logic [15:0] w802;
        logic [15:0] v;
        e0 = errors;
        rand16(data);
        rand16(bval);
        clear_image();
        w801 = fill_word('h801);
        w802 = fill_word('h802);
        put_ldi(1, data);
        put_ldi(2, 16'h1000);
        put_ldi(3, 16'h1003);
        put_ldi(4, bval);
        put_ldi(5, 16'h1004);
        put(enc(OP_ST, 1, 2, 3'd0));
        // odd address hits the high lane, even the low lane
        put(enc(OP_STB, 4, 3, 3'd0));
        put(enc(OP_STB, 4, 5, 3'd0));
        put(enc(OP_LD, 6, 2, 3'd0));
        put(enc(OP_LD, 7, 5, 3'd0));
        put(enc(OP_HALT, 0, 0, 3'd0));
        apply_reset();
        wait_halt("store_and_load", 11);
        check("store_and_load word 0x1000", data, mem['h800]);
        check("store_and_load word 0x1002", {bval[7:0], w801[7:0]}, mem['h801]);
        check("store_and_load word 0x1004", {w802[15:8], bval[7:0]}, mem['h802]);
        check("store_and_load word 0x0ffe", fill_word('h7ff), mem['h7ff]);
        check("store_and_load word 0x1006", fill_word('h803), mem['h803]);
        read_reg(6, v);
        check("store_and_load r6", data, v);
        read_reg(7, v);
        check("store_and_load r7", {w802[15:8], bval[7:0]}, v);
        end_test("store_and_load", e0);
    endtask

    task automatic countdown_loop();
        int          e0;
        int          n;
        int          loop_addr;
        logic [15:0] r;
        logic [15:0] v;
        logic  [7:0] f;
        e0 = errors;
        rand16(r);
        n = 4 + int'(r[2:0]);
        clear_image();
        put_ldi(1, 16'(n));
        put_ldi(2, 16'd1);
        put_ldi(3, 16'd0);
        loop_addr = ptr * 2;
        put_alu(ALU_ADD, 3, 1);
        put_alu(ALU_SUB, 1, 2);
        put(enc(OP_JNZ, 0, 0, 3'd0));
        put(16'(loop_addr));
        put(enc(OP_HALT, 0, 0, 3'd0));
        apply_reset();
        wait_halt("countdown_loop", 3 + 3 * n + 1);
        read_reg(3, v);
        check("countdown_loop sum", 16'(n * (n + 1) / 2), v);
        read_reg(1, v);
        check("countdown_loop counter", 16'd0, v);
        read_byte(16, f);
        check("countdown_loop flags", 16'h0001, 16'(f));
        end_test("countdown_loop", e0);
    endtask

    task automatic stores_after_halt();
        int e0;
        e0 = errors;
        clear_image();
        put_ldi(1, 16'h2000);
        put_ldi(2, 16'hbeef);
        put(enc(OP_HALT, 0, 0, 3'd0));
        // never reached
        put(enc(OP_ST, 2, 1, 3'd0));
        put(enc(OP_STB, 2, 1, 3'd0));
        apply_reset();
        wait_halt("stores_after_halt", 3);
        repeat (64) @(posedge clk);
        @(negedge clk);
        check("stores_after_halt halted", 16'd1, 16'(halted));
        check("stores_after_halt word 0x2000", fill_word('h1000), mem['h1000]);
        end_test("stores_after_halt", e0);
    endtask

    initial begin
        arst_n = 1'b0;
        dmp_addr = 8'd0;
        errors = 0;
        checks = 0;
        tests = 0;
        reset_defaults();
        load_all_registers();
        alu_operations();
        store_and_load();
        countdown_loop();
        stores_after_halt();
        errors = errors + dut.u_assertions.fail_count;
        $display("summary: %0d tests, %0d checks, %0d errors", tests, checks, errors);
        if (errors == 0) begin
            $display("ALL CHECKS PASSED");
        end else begin
            $display("CHECKS FAILED");
        end
        $finish;
    end

endmodule

// File: filelist.f
design/cpu_pkg.sv
design/cpu_alu.sv
design/cpu_regs.sv
design/cpu_ramctl.sv
design/cpu_ctrl.sv
design/cpu_core.sv
tests/cpu_assertions.sv
tests/cpu_tb.sv

// File: run.sh
#!/bin/sh
# build and run the cpu testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -j 0 --top-module cpu_tb \
    -f filelist.f -Mdir obj_dir > build.log 2>&1
if [ $? -ne 0 ]; then
    cat build.log
    echo "build failed"
    exit 1
fi

./obj_dir/Vcpu_tb +verilator+error+limit+100 > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -qx "ALL CHECKS PASSED" sim.log; then
    exit 0
fi
exit 1
